// File: src/coll_pkg.sv
package coll_pkg;

	//////////////////////////////////////////////////
	// widths

	localparam int COORD_W    = 3;  // one mesh coordinate
	localparam int RANK_W     = 9;
	localparam int CTX_W      = 8;
	localparam int TAG_W      = 8;
	localparam int OP_W       = 4;
	localparam int ALG_W      = 2;
	localparam int PAYLOAD_W  = 32;
	localparam int CHILDREN_W = 3;
	localparam int LG_W       = 4;  // log2 of communicator size
	localparam int NUM_NBR    = 3;  // neighbor slots per entry
	localparam int NBR_SEL_W  = $clog2(NUM_NBR);
	localparam int FLIT_W     = 82;

	// node address, z is the top coordinate
	typedef struct packed {
		logic [COORD_W-1:0] z;
		logic [COORD_W-1:0] y;
		logic [COORD_W-1:0] x;
	} addr_t;

	//////////////////////////////////////////////////
	// packets

	// 81 valid | 80-72 dst | 71-63 src | 62-54 rank | 53-46 ctx
	// 45-38 tag | 37-36 algtype | 35-32 op | 31-0 payload
	typedef struct packed {
		logic                  valid;
		addr_t                 dst;
		addr_t                 src;
		logic [RANK_W-1:0]     rank;
		logic [CTX_W-1:0]      ctx;
		logic [TAG_W-1:0]      tag;
		logic [ALG_W-1:0]      algtype;
		logic [OP_W-1:0]       op;
		logic [PAYLOAD_W-1:0]  payload;
	} pkt_in_t;

	// children on top, 84-82
	typedef struct packed {
		logic [CHILDREN_W-1:0] children;
		pkt_in_t               flit;
	} pkt_out_t;

	//////////////////////////////////////////////////
	// communicator table entry, 43 bits

	typedef struct packed {
		logic [RANK_W-1:0]      local_rank;
		logic [CHILDREN_W-1:0]  children;
		logic [LG_W-1:0]        lg_commsize;
		addr_t [NUM_NBR-1:0]    nbr;  // slot 0 in the low bits
	} comm_entry_t;

	// op codes kept in this stage
	localparam logic [OP_W-1:0] OP_NONE            = 4'd0;  // never addressed
	localparam logic [OP_W-1:0] OP_LARGE_ALLGATHER = 4'd5;
	localparam logic [OP_W-1:0] OP_GATHER          = 4'd7;
	localparam logic [OP_W-1:0] OP_SHORT_REDUCE    = 4'd8;

endpackage

// File: src/comm_table.sv
`timescale 1ns/1ps

module comm_table #(
	parameter int NUM_CONTEXTS = 4
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         cfg_we,
	input  logic [coll_pkg::CTX_W-1:0]   cfg_ctx,
	input  coll_pkg::comm_entry_t        cfg_entry,
	input  logic [coll_pkg::CTX_W-1:0]   ctx,
	output coll_pkg::comm_entry_t        entry
);
	import coll_pkg::*;

	localparam int IDX_W = (NUM_CONTEXTS > 1) ? $clog2(NUM_CONTEXTS) : 1;

	comm_entry_t tbl [NUM_CONTEXTS];  // one entry per context id

	logic cfg_hit;  // write lands inside the table
	logic rd_hit;   // lookup context exists

	assign cfg_hit = (cfg_ctx < NUM_CONTEXTS);
	assign rd_hit  = (ctx < NUM_CONTEXTS);

	//////////////////////////////////////////////////
	// config writes

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_CONTEXTS; i++) begin
				tbl[i] <= '0;  // table starts empty
			end
		end else if (cfg_we && cfg_hit) begin
			tbl[cfg_ctx[IDX_W-1:0]] <= cfg_entry;
		end
	end

	//////////////////////////////////////////////////
	// lookup by packet context, no register

	always_comb begin
		if (rd_hit) begin
			entry = tbl[ctx[IDX_W-1:0]];
		end else begin
			entry = '0;  // unknown context looks like rank 0, no nbrs
		end
	end

	// config master must stay within the table depth
	a_cfg_in_range: assert property (
		@(posedge clk) disable iff (rst)
		cfg_we |-> cfg_hit
	) else $error("config write to context %0d beyond table", cfg_ctx);

endmodule

// File: src/uptree_route.sv
`timescale 1ns/1ps

module uptree_route #(
	parameter coll_pkg::addr_t NODE_ADDR = '0
) (
	input  coll_pkg::comm_entry_t entry,
	output coll_pkg::addr_t       parent
);
	import coll_pkg::*;

	logic [LG_W-1:0] slot;  // neighbor slot of the parent
	logic            slot_ok;

	// parent sits below the child slots at lg - children - 1
	assign slot = entry.lg_commsize - LG_W'(entry.children) - LG_W'(1);
	assign slot_ok = (slot < NUM_NBR);

	//////////////////////////////////////////////////
	// parent hop

	always_comb begin
		if (entry.local_rank == '0) begin
			parent = NODE_ADDR;  // root of the tree keeps it
		end else if (slot_ok) begin
			parent = entry.nbr[slot[NBR_SEL_W-1:0]];
		end else begin
			parent = '0;  // bad entry flagged below
		end
	end

	// a non-root entry must point at a real neighbor slot
	// table is unknown before its first reset edge
	always_comb begin
		a_slot_range: assert #0 ($isunknown(entry) || entry.local_rank == '0 || slot_ok)
			else $error("uptree slot %0d out of range", slot);
	end

endmodule

// File: src/ring_route.sv
`timescale 1ns/1ps

module ring_route #(
	parameter coll_pkg::addr_t NODE_ADDR = '0,
	parameter coll_pkg::addr_t ROOT_ADDR = '0
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  valid,
	input  logic                  is_ring,     // large allgather op
	input  logic                  from_guest,  // src is another node
	input  coll_pkg::comm_entry_t entry,
	output coll_pkg::addr_t       next_hop,
	output logic                  home
);
	import coll_pkg::*;

	logic [RANK_W:0]   comm_size;  // 2^lg plus a spare bit
	logic [RANK_W-1:0] last_rank;
	logic [LG_W-1:0]   slot;
	logic              is_last;

	assign comm_size = (RANK_W+1)'(1) << entry.lg_commsize;
	assign last_rank = RANK_W'(comm_size - 1'b1);
	assign is_last   = (entry.local_rank == last_rank);
	assign slot      = entry.lg_commsize - LG_W'(1);  // ring neighbor slot

	//////////////////////////////////////////////////
	// next hop on the ring

	always_comb begin
		if (home) begin
			next_hop = NODE_ADDR;  // replay goes to this node
		end else if (is_last) begin
			next_hop = ROOT_ADDR;  // last rank closes the ring
		end else if (slot < NUM_NBR) begin
			next_hop = entry.nbr[slot[NBR_SEL_W-1:0]];
		end else begin
			next_hop = '0;
		end
	end

	//////////////////////////////////////////////////
	// home/replay bit

	// guest packet goes out onward first and home on its replay
	always_ff @(posedge clk) begin
		if (rst) begin
			home <= 1'b0;
		end else if (valid) begin
			home <= from_guest && is_ring && !home;
		end else begin
			home <= 1'b0;  // bubble drops any pending replay
		end
	end

	// the cycle after a guest packet must present its replay
	a_home_replay: assert property (
		@(posedge clk) disable iff (rst)
		(valid && home) |-> (is_ring && from_guest)
	) else $error("ring home bit set but no guest replay presented");

endmodule

// File: src/route_select.sv
`timescale 1ns/1ps

module route_select #(
	parameter coll_pkg::addr_t NODE_ADDR = '0,
	parameter coll_pkg::addr_t ROOT_ADDR = '0
) (
	input  logic                              clk,
	input  logic                              rst,
	input  coll_pkg::pkt_in_t                 packet_in,
	input  coll_pkg::comm_entry_t             entry,
	input  coll_pkg::addr_t                   parent,
	input  coll_pkg::addr_t                   next_hop,
	input  logic                              home,
	output logic                              is_ring,
	output logic                              from_guest,
	output logic                              reroute,
	output logic [coll_pkg::OP_W-1:0]         op_q,
	output logic [coll_pkg::ALG_W-1:0]        alg_q,
	output coll_pkg::addr_t                   dst_q,
	output logic [coll_pkg::CHILDREN_W-1:0]   children_q,
	output logic                              rd_en
);
	import coll_pkg::*;

	logic                  addressed;   // packet is for this node
	addr_t                 dst_c;       // chosen next hop
	logic [ALG_W-1:0]      alg_c;
	logic [CHILDREN_W-1:0] children_c;
	logic                  rd_c;

	assign addressed  = (packet_in.dst == NODE_ADDR) && (packet_in.op != OP_NONE);
	assign from_guest = (packet_in.src != NODE_ADDR);
	assign is_ring    = (packet_in.op == OP_LARGE_ALLGATHER);
	assign reroute    = addressed && (dst_c != NODE_ADDR);  // leaves with our src/rank

	//////////////////////////////////////////////////
	// per-op destination

	always_comb begin
		dst_c      = packet_in.dst;      // pass-through defaults
		alg_c      = packet_in.algtype;
		children_c = '0;
		rd_c       = 1'b1;
		if (addressed) begin
			alg_c = '0;  // algtype reset once we route it
			case (packet_in.op)
				OP_SHORT_REDUCE: begin
					dst_c      = parent;
					children_c = entry.children;  // parent waits on this many
				end
				OP_GATHER: begin
					dst_c = parent;
				end
				OP_LARGE_ALLGATHER: begin
					dst_c = next_hop;
					rd_c  = home || !from_guest;  // hold guest pkt for its replay
				end
				default: begin
					dst_c = ROOT_ADDR;  // root handles any other op
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// output registers

	always_ff @(posedge clk) begin
		if (rst) begin
			op_q       <= '0;
			alg_q      <= '0;
			dst_q      <= '0;
			children_q <= '0;
			rd_en      <= 1'b1;  // fifo free to pop out of reset
		end else begin
			op_q       <= packet_in.op;
			alg_q      <= alg_c;
			dst_q      <= dst_c;
			children_q <= children_c;
			rd_en      <= rd_c;
		end
	end

	// a ring stall lasts one cycle until the replay
	a_stall_once: assert property (
		@(posedge clk) disable iff (rst)
		!rd_en |=> rd_en
	) else $error("rd_en low for two cycles in a row");

endmodule

// File: src/pkt_rewrite.sv
`timescale 1ns/1ps

module pkt_rewrite #(
	parameter coll_pkg::addr_t NODE_ADDR = '0
) (
	input  logic                              clk,
	input  logic                              rst,
	input  coll_pkg::pkt_in_t                 packet_in,
	input  coll_pkg::comm_entry_t             entry,
	input  logic                              reroute,
	input  logic [coll_pkg::OP_W-1:0]         op_q,
	input  logic [coll_pkg::ALG_W-1:0]        alg_q,
	input  coll_pkg::addr_t                   dst_q,
	input  logic [coll_pkg::CHILDREN_W-1:0]   children_q,
	output coll_pkg::pkt_out_t                packet_out
);
	import coll_pkg::*;

	logic [PAYLOAD_W-1:0] payload_q;
	logic [TAG_W-1:0]     tag_q;
	logic [CTX_W-1:0]     ctx_q;
	logic [RANK_W-1:0]    rank_q;
	logic [RANK_W-1:0]    loc_rank_q;  // our rank in that context
	addr_t                src_q;
	logic                 valid_q;
	logic                 reroute_q;

	if ($bits(pkt_in_t) != FLIT_W || $bits(pkt_out_t) != FLIT_W + CHILDREN_W) begin : g_width
		$error("packet struct widths do not match the flit layout");
	end

	//////////////////////////////////////////////////
	// hold the rest of the packet

	always_ff @(posedge clk) begin
		if (rst || !packet_in.valid) begin
			payload_q  <= '0;  // bubbles leave as all zero
			tag_q      <= '0;
			ctx_q      <= '0;
			rank_q     <= '0;
			loc_rank_q <= '0;
			src_q      <= '0;
			valid_q    <= 1'b0;
			reroute_q  <= 1'b0;
		end else begin
			payload_q  <= packet_in.payload;
			tag_q      <= packet_in.tag;
			ctx_q      <= packet_in.ctx;
			rank_q     <= packet_in.rank;
			loc_rank_q <= entry.local_rank;
			src_q      <= packet_in.src;
			valid_q    <= 1'b1;
			reroute_q  <= reroute;
		end
	end

	// forwarded packets carry this node as sender, kept ones the original
	always_comb begin
		packet_out.children     = children_q;
		packet_out.flit.valid   = valid_q;
		packet_out.flit.dst     = dst_q;
		packet_out.flit.src     = reroute_q ? NODE_ADDR : src_q;
		packet_out.flit.rank    = reroute_q ? loc_rank_q : rank_q;
		packet_out.flit.ctx     = ctx_q;
		packet_out.flit.tag     = tag_q;
		packet_out.flit.algtype = alg_q;
		packet_out.flit.op      = op_q;
		packet_out.flit.payload = payload_q;
	end

endmodule

// File: src/coll_router.sv
`timescale 1ns/1ps

module coll_router #(
	parameter coll_pkg::addr_t NODE_ADDR    = coll_pkg::addr_t'(9'd1),
	parameter coll_pkg::addr_t ROOT_ADDR    = '0,
	parameter int              NUM_CONTEXTS = 4
) (
	input  logic                         clk,
	input  logic                         rst,
	input  coll_pkg::pkt_in_t            packet_in,  // head of input fifo
	input  logic                         cfg_we,
	input  logic [coll_pkg::CTX_W-1:0]   cfg_ctx,
	input  coll_pkg::comm_entry_t        cfg_entry,
	output coll_pkg::pkt_out_t           packet_out,
	output logic                         rd_en       // low = present same pkt again
);
	import coll_pkg::*;

	comm_entry_t           entry;  // context lookup
	addr_t                 parent;
	addr_t                 next_hop;
	logic                  home;
	logic                  is_ring;
	logic                  from_guest;
	logic                  reroute;
	logic [OP_W-1:0]       op_q;
	logic [ALG_W-1:0]      alg_q;
	addr_t                 dst_q;
	logic [CHILDREN_W-1:0] children_q;

	//////////////////////////////////////////////////
	// table and candidate hops

	comm_table #(.NUM_CONTEXTS(NUM_CONTEXTS)) u_table (
		.clk(clk), .rst(rst), .cfg_we(cfg_we), .cfg_ctx(cfg_ctx),
		.cfg_entry(cfg_entry), .ctx(packet_in.ctx), .entry(entry)
	);

	uptree_route #(.NODE_ADDR(NODE_ADDR)) u_uptree (
		.entry(entry), .parent(parent)
	);

	ring_route #(.NODE_ADDR(NODE_ADDR), .ROOT_ADDR(ROOT_ADDR)) u_ring (
		.clk(clk), .rst(rst), .valid(packet_in.valid), .is_ring(is_ring),
		.from_guest(from_guest), .entry(entry), .next_hop(next_hop), .home(home)
	);

	//////////////////////////////////////////////////
	// select and output stage

	route_select #(.NODE_ADDR(NODE_ADDR), .ROOT_ADDR(ROOT_ADDR)) u_select (
		.clk(clk), .rst(rst), .packet_in(packet_in), .entry(entry),
		.parent(parent), .next_hop(next_hop), .home(home),
		.is_ring(is_ring), .from_guest(from_guest), .reroute(reroute),
		.op_q(op_q), .alg_q(alg_q), .dst_q(dst_q), .children_q(children_q),
		.rd_en(rd_en)
	);

	pkt_rewrite #(.NODE_ADDR(NODE_ADDR)) u_rewrite (
		.clk(clk), .rst(rst), .packet_in(packet_in), .entry(entry),
		.reroute(reroute), .op_q(op_q), .alg_q(alg_q), .dst_q(dst_q),
		.children_q(children_q), .packet_out(packet_out)
	);

endmodule

// File: dv/coll_router_tb.sv
`timescale 1ns/1ps

module coll_router_tb;
	import coll_pkg::*;

	localparam addr_t NODE       = 9'o001;  // z-y-x 0-0-1
	localparam addr_t ROOT       = 9'o000;
	localparam int    RST_CYCLES = 16;

	logic             clk;
	logic             rst;
	pkt_in_t          packet_in;
	logic             cfg_we;
	logic [CTX_W-1:0] cfg_ctx;
	comm_entry_t      cfg_entry;
	pkt_out_t         packet_out;
	logic             rd_en;

	// one slot per golden line, C or P
	byte              kind_q[$];
	logic [CTX_W-1:0] cfg_ctx_q[$];
	comm_entry_t      ent_q[$];
	pkt_in_t          in_q[$];
	pkt_out_t         exp_q[$];
	logic             rd_q[$];
	int               fld[20];  // scratch for one parsed line

	int errors      = 0;
	int gold_errors = 0;  // bad or inconsistent golden lines
	int checks      = 0;
	int cycles      = 0;
	int cycle_limit = 0;  // known once the vectors are loaded

	coll_router #(.NODE_ADDR(NODE), .ROOT_ADDR(ROOT), .NUM_CONTEXTS(4)) dut0 (
		.clk(clk), .rst(rst), .packet_in(packet_in), .cfg_we(cfg_we), .cfg_ctx(cfg_ctx),
		.cfg_entry(cfg_entry), .packet_out(packet_out), .rd_en(rd_en)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns period
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("timeout, the run went past %0d cycles without finishing", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// golden file

	// packet fields from fld, starting at base
	function automatic pkt_in_t pkt_from(int base);
		pkt_in_t p;
		p.valid   = fld[base][0];
		p.dst     = fld[base+1][8:0];
		p.src     = fld[base+2][8:0];
		p.rank    = fld[base+3][RANK_W-1:0];
		p.ctx     = fld[base+4][CTX_W-1:0];
		p.tag     = fld[base+5][TAG_W-1:0];
		p.algtype = fld[base+6][ALG_W-1:0];
		p.op      = fld[base+7][OP_W-1:0];
		p.payload = fld[base+8];
		return p;
	endfunction

	function automatic int load_golden();
		int          fd;
		int          rc;
		string       line;
		pkt_out_t    e;
		comm_entry_t ce;
		fd = $fopen("dv/coll_router_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden file dv/coll_router_golden.txt");
			return 0;
		end
		while ($fgets(line, fd) > 0) begin
			e  = '0;
			ce = '0;
			rc = 0;
			if (line[0] == "C") begin  // ctx rank children lg nbr2 nbr1 nbr0
				rc = $sscanf(line, "C %d %d %d %d %o %o %o",
					fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6]);
				ce.local_rank  = fld[1][RANK_W-1:0];
				ce.children    = fld[2][CHILDREN_W-1:0];
				ce.lg_commsize = fld[3][LG_W-1:0];
				ce.nbr[2]      = fld[4][8:0];
				ce.nbr[1]      = fld[5][8:0];
				ce.nbr[0]      = fld[6][8:0];
			end else if (line[0] == "P") begin
				rc = $sscanf(line,
					"P %d %o %o %d %d %h %d %d %h %d %d %o %o %d %d %h %d %d %h %d",
					fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
					fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
					fld[15], fld[16], fld[17], fld[18], fld[19]);
				e.children = fld[9][CHILDREN_W-1:0];
				e.flit     = pkt_from(10);
			end
			if ((line[0] == "C" && rc == 7) || (line[0] == "P" && rc == 20)) begin
				kind_q.push_back(line[0]);
				cfg_ctx_q.push_back(fld[0][CTX_W-1:0]);
				ent_q.push_back(ce);
				in_q.push_back(pkt_from(0));
				exp_q.push_back(e);
				rd_q.push_back(fld[19][0]);
			end else if (line[0] == "C" || line[0] == "P") begin
				gold_errors++;
				$display("golden line could not be parsed: %s", line);
			end
		end
		$fclose(fd);
		if (kind_q.size() == 0)
			$display("the golden file holds no vectors");
		return kind_q.size();
	endfunction

	//////////////////////////////////////////////////
	// checks

	task automatic compare_outputs(input pkt_out_t exp_out, input logic exp_rd, input int vec);
		checks += 2;
		assert (packet_out === exp_out) else begin
			errors++;
			$display("Error at %0t ns: vector %0d packet_out expected %h, got %h",
				$time, vec, exp_out, packet_out);
		end
		assert (rd_en === exp_rd) else begin
			errors++;
			$display("Error at %0t ns: vector %0d rd_en expected %b, got %b",
				$time, vec, exp_rd, rd_en);
		end
	endtask

	initial begin
		int       num_vec;
		bit       replay;     // fifo presents the held packet again
		bit       pend;
		pkt_in_t  held;
		pkt_out_t pend_out;
		logic     pend_rd;
		rst       = 1'b1;
		packet_in = '0;
		cfg_we    = 1'b0;
		cfg_ctx   = '0;
		cfg_entry = '0;
		replay    = 1'b0;
		pend      = 1'b0;
		held      = '0;
		num_vec   = load_golden();
		if (num_vec == 0) begin
			$display("Simulation failed");
			$finish;
		end else begin
			cycle_limit = RST_CYCLES + 4 * num_vec + 20;
			repeat (RST_CYCLES) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;
			checks += 2;
			assert (rd_en === 1'b1) else begin
				errors++;
				$display("Error at %0t ns: rd_en after reset expected 1, got %b", $time, rd_en);
			end
			assert (packet_out.flit.valid === 1'b0) else begin
				errors++;
				$display("Error at %0t ns: valid after reset expected 0, got %b",
					$time, packet_out.flit.valid);
			end
			for (int idx = 0; idx < num_vec; idx++) begin
				@(negedge clk);
				if (pend)
					compare_outputs(pend_out, pend_rd, idx - 1);
				if (kind_q[idx] == "C") begin
					cfg_we    = 1'b1;
					cfg_ctx   = cfg_ctx_q[idx];
					cfg_entry = ent_q[idx];
					packet_in = '0;  // bubble while writing
					pend_out  = '0;
					pend_rd   = 1'b1;
				end else begin
					cfg_we = 1'b0;
					assert (!replay || in_q[idx] === held) else begin
						gold_errors++;
						$display("golden vector %0d should repeat the held packet", idx);
					end
					if (!replay)
						held = in_q[idx];  // pop the next fifo entry
					packet_in = held;
					pend_out  = exp_q[idx];
					pend_rd   = rd_q[idx];
					replay    = !rd_q[idx];
				end
				pend = 1'b1;
			end
			@(negedge clk);
			cfg_we    = 1'b0;
			packet_in = '0;
			compare_outputs(pend_out, pend_rd, num_vec - 1);
			$display("%0d checks, %0d value errors, %0d golden file errors",
				checks, errors, gold_errors);
			if (errors == 0 && gold_errors == 0) begin
				$display("Simulation completed successfully");
			end else begin
				$display("Simulation failed");
			end
			$finish;
		end
	end

endmodule

// File: list.f
src/coll_pkg.sv
src/comm_table.sv
src/uptree_route.sv
src/ring_route.sv
src/route_select.sv
src/pkt_rewrite.sv
src/coll_router.sv
dv/coll_router_tb.sv

// File: dv/coll_router_golden.txt
# C ctx local_rank children lg_commsize nbr2 nbr1 nbr0
# P valid dst src rank ctx tag alg op payload, then expected children valid dst src rank
#   ctx tag alg op payload rd_en; addresses octal z-y-x, tag and payload hex, rest decimal
C 0 3 1 3 011 012 013
C 1 0 2 2 021 022 023
C 2 3 0 2 031 032 033
# invalid input, pass-through, op 0 to this node
P 0 023 004 7 1 11 1 3 12345678  0 0 023 000 0 0 00 1 3 00000000 1
P 1 034 002 5 0 a5 2 8 deadbeef  0 1 034 002 5 0 a5 2 8 deadbeef 1
P 1 001 002 3 0 91 1 0 12121212  0 1 001 002 3 0 91 1 0 12121212 1
# uptree with rank 3, then rank 0
P 1 001 002 6 0 3c 1 8 0000abcd  1 1 012 001 3 0 3c 0 8 0000abcd 1
P 1 001 003 4 0 40 1 7 00001111  0 1 012 001 3 0 40 0 7 00001111 1
P 1 001 002 6 1 41 1 8 00002222  2 1 001 002 6 1 41 0 8 00002222 1
P 1 001 005 2 1 42 3 7 00003333  0 1 001 005 2 1 42 0 7 00003333 1
# ring, guest and replay, own packet, last rank and replay
P 1 001 004 9 0 50 2 5 00004444  0 1 011 001 3 0 50 0 5 00004444 0
P 1 001 004 9 0 50 2 5 00004444  0 1 001 004 9 0 50 0 5 00004444 1
P 1 001 001 0 1 51 2 5 00005555  0 1 022 001 0 1 51 0 5 00005555 1
P 1 001 007 2 2 52 1 5 00006666  0 1 000 001 3 2 52 0 5 00006666 0
P 1 001 007 2 2 52 1 5 00006666  0 1 001 007 2 2 52 0 5 00006666 1
# other op goes to root
P 1 001 006 1 0 60 3 3 77777777  0 1 000 001 3 0 60 0 3 77777777 1
# table rewrites change the route
P 1 001 006 4 3 70 0 7 88888888  0 1 001 006 4 3 70 0 7 88888888 1
C 3 2 0 2 041 042 043
P 1 001 006 4 3 71 0 7 99999999  0 1 042 001 2 3 71 0 7 99999999 1
C 0 5 1 4 014 015 016
P 1 001 003 1 0 80 2 8 0badf00d  1 1 014 001 5 0 80 0 8 0badf00d 1
P 1 000 001 1 2 90 3 5 cafef00d  0 1 000 001 1 2 90 3 5 cafef00d 1
